//--- files.f
+incdir+test
source/cap_pkg.sv
source/frame_pattern_gen.sv
source/pattern_source.sv
source/tpram.sv
source/buffer_writer.sv
source/axil_readout.sv
source/capture_top.sv
test/tb_capture_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_capture_top -f files.f -o sim_capture
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_capture > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0

//--- source/axil_readout.sv
`timescale 1ns/1ps

module axil_readout (
  input  logic                                clk,
  input  logic                                rst_n,
  // Write channels
  input  logic [cap_pkg::AXI_ADDR_WIDTH-1:0]  awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [cap_pkg::SAMPLE_WIDTH-1:0]    wdata,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  // Read channels
  input  logic [cap_pkg::AXI_ADDR_WIDTH-1:0]  araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [cap_pkg::SAMPLE_WIDTH-1:0]    rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready,
  // Writer side
  input  logic                                read_bank,
  input  logic [cap_pkg::FRAME_NUM_WIDTH-1:0] read_frame,
  input  logic                                bank_valid,
  output logic                                freeze,
  // RAM port B
  output logic                                rd_en,
  output logic [cap_pkg::RAM_ADDR_WIDTH-1:0]  rd_addr,
  input  logic [cap_pkg::RAM_WIDTH-1:0]       rd_data
);
  import cap_pkg::*;

  typedef enum logic [1:0] {
    KIND_NONE,
    KIND_CTRL,
    KIND_STAT,
    KIND_SAMPLE
  } rd_kind_t;

  logic                      aw_fire;
  logic                      ar_fire;
  logic [AXI_ADDR_WIDTH-1:0] ar_off;
  logic                      ar_in_window;
  rd_kind_t                  ar_kind;
  logic                      rd_pend;
  rd_kind_t                  pend_kind;
  logic [LANE_SEL_WIDTH-1:0] pend_lane;
  logic [SAMPLE_WIDTH-1:0]   read_word;

  //////////////////////////////
  // Write path
  //////////////////////////////

  // Ready pulse implies both valids were seen
  assign aw_fire = awready & awvalid & wvalid;

  // One-cycle ready pulse, blocked while a response waits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      freeze  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~bvalid & ~awready;
      wready  <= awvalid & wvalid & ~bvalid & ~awready;
      if (aw_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      // Control register, freeze in bit 0
      if (aw_fire && (awaddr == ADDR_CONTROL)) begin
        freeze <= wdata[0];
      end
    end
  end

  // Only control accepts writes
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      bresp <= (awaddr == ADDR_CONTROL) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  //////////////////////////////
  // Read address decode
  //////////////////////////////

  assign ar_fire = arready & arvalid;
  assign ar_off  = araddr - ADDR_SAMPLE_BASE;
  assign ar_in_window = (araddr >= ADDR_SAMPLE_BASE) &&
                        (ar_off < AXI_ADDR_WIDTH'(SAMPLE_WINDOW_BYTES));

  always_comb begin
    if (araddr == ADDR_CONTROL) begin
      ar_kind = KIND_CTRL;
    end else if (araddr == ADDR_STATUS) begin
      ar_kind = KIND_STAT;
    end else if (ar_in_window) begin
      ar_kind = KIND_SAMPLE;
    end else begin
      ar_kind = KIND_NONE;
    end
  end

  // RAM read goes out in the accepting cycle
  // Word index above the lane bits, bank from the writer
  assign rd_en   = ar_fire & (ar_kind == KIND_SAMPLE);
  assign rd_addr = {read_bank, ar_off[BYTE_SEL_WIDTH+LANE_SEL_WIDTH +: WORD_ADDR_WIDTH]};

  //////////////////////////////
  // Read response
  //////////////////////////////

  // Accept, RAM latency, then rvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      rd_pend <= ar_fire;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      // Idle again once the response is taken
      if (ar_fire) begin
        arready <= 1'b0;
      end else if (!rd_pend && (!rvalid || rready)) begin
        arready <= 1'b1;
      end
    end
  end

  // Data source for the pending read
  always_comb begin
    case (pend_kind)
      KIND_CTRL:   read_word = SAMPLE_WIDTH'(freeze);
      // Bank 17, valid 16, frame number 15..0
      KIND_STAT:   read_word = SAMPLE_WIDTH'({read_bank, bank_valid, read_frame});
      KIND_SAMPLE: read_word = rd_data[pend_lane*SAMPLE_WIDTH +: SAMPLE_WIDTH];
      default:     read_word = '0;
    endcase
  end

  // Kind and lane kept from the address beat
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      pend_kind <= ar_kind;
      pend_lane <= ar_off[BYTE_SEL_WIDTH +: LANE_SEL_WIDTH];
    end
    if (rd_pend) begin
      rdata <= read_word;
      rresp <= (pend_kind == KIND_NONE) ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

//--- source/buffer_writer.sv
`timescale 1ns/1ps

module buffer_writer (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [cap_pkg::RAM_WIDTH-1:0]       word_data,
  input  logic                                word_valid,
  input  logic                                word_last,
  input  logic [cap_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
  input  logic                                freeze,
  output logic                                wr_en,
  output logic [cap_pkg::WORD_ADDR_WIDTH:0]   wr_addr,
  output logic [cap_pkg::RAM_WIDTH-1:0]       wr_data,
  output logic                                read_bank,
  output logic [cap_pkg::FRAME_NUM_WIDTH-1:0] read_frame,
  output logic                                bank_valid
);
  import cap_pkg::*;

  logic [WORD_ADDR_WIDTH-1:0] word_idx;
  logic                       write_bank;
  logic                       frame_done;

  //////////////////////////////
  // RAM port A
  //////////////////////////////

  // No back-pressure, every valid word lands at once
  assign wr_en   = word_valid;
  assign wr_addr = {write_bank, word_idx};
  assign wr_data = word_data;

  assign frame_done = word_valid & word_last;

  // Word position inside the frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_idx <= '0;
    end else if (frame_done) begin
      word_idx <= '0;
    end else if (word_valid) begin
      word_idx <= word_idx + 1'b1;
    end
  end

  //////////////////////////////
  // Bank handover
  //////////////////////////////

  // Finished frame becomes readable unless the host froze it
  // Frozen case keeps writing into the spare bank
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_bank <= 1'b0;
      read_bank  <= 1'b0;
      read_frame <= '0;
      bank_valid <= 1'b0;
    end else if (frame_done && !freeze) begin
      read_bank  <= write_bank;
      read_frame <= frame_num;
      bank_valid <= 1'b1;
      // Ping-pong toggle
      write_bank <= ~write_bank;
    end
  end

endmodule

//--- source/cap_pkg.sv
package cap_pkg;

  //////////////////////////////
  // Frame and sample geometry
  //////////////////////////////

  // One RAM word carries four host samples
  localparam int RAM_WIDTH       = 128;
  localparam int SAMPLE_WIDTH    = 32;
  localparam int HALF_WIDTH      = SAMPLE_WIDTH / 2;
  localparam int LANES           = RAM_WIDTH / SAMPLE_WIDTH;
  localparam int LANE_SEL_WIDTH  = $clog2(LANES);
  localparam int FRAME_WORDS     = 1024;
  localparam int WORD_ADDR_WIDTH = $clog2(FRAME_WORDS);
  // Bank bit on top of the word index
  localparam int RAM_ADDR_WIDTH  = WORD_ADDR_WIDTH + 1;

  // Restart interval of the pattern source
  localparam int FRAME_PERIOD     = 1206;
  localparam int PERIOD_CNT_WIDTH = $clog2(FRAME_PERIOD);
  localparam int FRAME_NUM_WIDTH  = 16;

  //////////////////////////////
  // AXI4-Lite address map
  //////////////////////////////

  localparam int AXI_ADDR_WIDTH = 16;
  // Byte offset bits inside one sample
  localparam int BYTE_SEL_WIDTH = $clog2(SAMPLE_WIDTH / 8);
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_CONTROL     = 16'h0000;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_STATUS      = 16'h0004;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_SAMPLE_BASE = 16'h4000;
  // 4096 samples, one per 32-bit slot
  localparam int SAMPLE_WINDOW_BYTES = FRAME_WORDS * LANES * (SAMPLE_WIDTH / 8);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- source/capture_top.sv
`timescale 1ns/1ps

module capture_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [cap_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [cap_pkg::SAMPLE_WIDTH-1:0]   wdata,
  input  logic                               wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  logic [cap_pkg::AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [cap_pkg::SAMPLE_WIDTH-1:0]   rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready
);
  import cap_pkg::*;

  // Source to writer
  logic [RAM_WIDTH-1:0]       word_data;
  logic                       word_valid;
  logic                       word_last;
  logic [FRAME_NUM_WIDTH-1:0] frame_num;
  // Writer to RAM and readout
  logic                       wr_en;
  logic [RAM_ADDR_WIDTH-1:0]  wr_addr;
  logic [RAM_WIDTH-1:0]       wr_data;
  logic                       read_bank;
  logic [FRAME_NUM_WIDTH-1:0] read_frame;
  logic                       bank_valid;
  logic                       freeze;
  // Readout to RAM
  logic                       rd_en;
  logic [RAM_ADDR_WIDTH-1:0]  rd_addr;
  logic [RAM_WIDTH-1:0]       rd_data;

  pattern_source u_source (
    .clk, .rst_n, .word_data, .word_valid, .word_last, .frame_num
  );

  buffer_writer u_writer (
    .clk, .rst_n, .word_data, .word_valid, .word_last, .frame_num, .freeze,
    .wr_en, .wr_addr, .wr_data, .read_bank, .read_frame, .bank_valid
  );

  // Two banks of FRAME_WORDS words
  tpram #(
    .DATA_WIDTH (RAM_WIDTH),
    .ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) u_ram (
    .clk, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
  );

  axil_readout u_readout (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .read_bank, .read_frame, .bank_valid, .freeze,
    .rd_en, .rd_addr, .rd_data
  );

endmodule

//--- source/frame_pattern_gen.sv
`timescale 1ns/1ps

module frame_pattern_gen (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                restart,
  input  logic                                active,
  input  logic [cap_pkg::WORD_ADDR_WIDTH-1:0] index,
  output logic [cap_pkg::RAM_WIDTH-1:0]       word_data,
  output logic                                word_valid,
  output logic                                word_last,
  output logic [cap_pkg::FRAME_NUM_WIDTH-1:0] frame_num
);
  import cap_pkg::*;

  logic [RAM_WIDTH-1:0] pattern;

  //////////////////////////////
  // Word pattern
  //////////////////////////////

  // Upper half frame number, lower half sample number 4*i+k
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      pattern[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = {
        frame_num[HALF_WIDTH-1:0],
        HALF_WIDTH'({index, LANE_SEL_WIDTH'(k)})
      };
    end
  end

  //////////////////////////////
  // Registered outputs
  //////////////////////////////

  // Frame counter, new number at every restart
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_num <= '0;
    end else if (restart) begin
      frame_num <= frame_num + 1'b1;
    end
  end

  // Valid and last flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
      word_last  <= 1'b0;
    end else begin
      word_valid <= active;
      word_last  <= active && (index == WORD_ADDR_WIDTH'(FRAME_WORDS - 1));
    end
  end

  // Payload only, flags tell when it counts
  always_ff @(posedge clk) begin
    word_data <= pattern;
  end

endmodule

//--- source/pattern_source.sv
`timescale 1ns/1ps

module pattern_source (
  input  logic                                clk,
  input  logic                                rst_n,
  output logic [cap_pkg::RAM_WIDTH-1:0]       word_data,
  output logic                                word_valid,
  output logic                                word_last,
  output logic [cap_pkg::FRAME_NUM_WIDTH-1:0] frame_num
);
  import cap_pkg::*;

  logic [PERIOD_CNT_WIDTH-1:0] period_cnt;
  logic                        restart;
  logic                        active;
  logic [WORD_ADDR_WIDTH-1:0]  index;

  //////////////////////////////
  // Period counter
  //////////////////////////////

  // Free running 0 .. FRAME_PERIOD-1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
    end else if (restart) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // Wrap point, stands in for the periodic internal reset
  assign restart = (period_cnt == PERIOD_CNT_WIDTH'(FRAME_PERIOD - 1));

  // Words go out in the first FRAME_WORDS counts
  assign active = (period_cnt < PERIOD_CNT_WIDTH'(FRAME_WORDS));

  // Gap after the frame is idle time
  // Word index is just the low counter bits
  assign index = period_cnt[WORD_ADDR_WIDTH-1:0];

  //////////////////////////////
  // Generator
  //////////////////////////////

  // Outputs follow the counter by one clock
  frame_pattern_gen u_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .restart    (restart),
    .active     (active),
    .index      (index),
    .word_data  (word_data),
    .word_valid (word_valid),
    .word_last  (word_last),
    .frame_num  (frame_num)
  );

endmodule

//--- source/tpram.sv
`timescale 1ns/1ps

module tpram #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  // Storage array
  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // Port A, write only
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Port B, one cycle read latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- test/capture_tb_tasks.svh
// Cycles allowed for one AXI handshake step
localparam int HANDSHAKE_LIMIT  = 50;
// Cycles allowed for a new frame to show up in the status register
localparam int FRAME_WAIT_LIMIT = 4 * FRAME_PERIOD;

// One finished read waiting for the compare process
typedef struct packed {
  logic [AXI_ADDR_WIDTH-1:0] addr;
  logic [SAMPLE_WIDTH-1:0]   got;
  logic [SAMPLE_WIDTH-1:0]   exp;
  logic [SAMPLE_WIDTH-1:0]   mask;
  logic [1:0]                resp_got;
  logic [1:0]                resp_exp;
} read_rec_t;

read_rec_t read_q[$];

// Frame number in the upper half, sample index 4*i+k in the lower half
function automatic logic [SAMPLE_WIDTH-1:0] expected_sample(input int frame, input int s);
  return {frame[15:0], s[15:0]};
endfunction

//////////////////////////////
// AXI4-Lite master
//////////////////////////////

task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                         input logic [SAMPLE_WIDTH-1:0] data, output logic [1:0] resp);
  int n;
  @(negedge clk);
  awaddr  = addr;
  wdata   = data;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  n = 0;
  while (!(awready && wready) && n < HANDSHAKE_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (!(awready && wready)) begin
    $display("Timeout at %0t: write to %h was never accepted", $time, addr);
    err_cnt++;
  end
  // Handshake completes on the coming rising edge
  @(negedge clk);
  awvalid = 1'b0;
  wvalid  = 1'b0;
  bready  = 1'b1;
  n = 0;
  while (!bvalid && n < HANDSHAKE_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (!bvalid) begin
    $display("Timeout at %0t: no write response for %h", $time, addr);
    err_cnt++;
  end
  resp = bresp;
  @(negedge clk);
  bready = 1'b0;
endtask

task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr,
                        output logic [SAMPLE_WIDTH-1:0] data, output logic [1:0] resp);
  int n;
  @(negedge clk);
  araddr  = addr;
  arvalid = 1'b1;
  n = 0;
  while (!arready && n < HANDSHAKE_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (!arready) begin
    $display("Timeout at %0t: read of %h was never accepted", $time, addr);
    err_cnt++;
  end
  @(negedge clk);
  arvalid = 1'b0;
  rready  = 1'b1;
  n = 0;
  while (!rvalid && n < HANDSHAKE_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (!rvalid) begin
    $display("Timeout at %0t: no read data for %h", $time, addr);
    err_cnt++;
  end
  // Sampled mid-cycle while rvalid is high
  data = rdata;
  resp = rresp;
  @(negedge clk);
  rready = 1'b0;
endtask

// Read and hand the result to the compare process
task automatic check_read(input logic [AXI_ADDR_WIDTH-1:0] addr,
                          input logic [SAMPLE_WIDTH-1:0] exp,
                          input logic [SAMPLE_WIDTH-1:0] mask, input logic [1:0] resp_exp);
  read_rec_t r;
  r.addr     = addr;
  r.exp      = exp;
  r.mask     = mask;
  r.resp_exp = resp_exp;
  axi_read(addr, r.got, r.resp_got);
  read_q.push_back(r);
endtask

task automatic read_sample(input int s, input int frame);
  check_read(AXI_ADDR_WIDTH'(ADDR_SAMPLE_BASE + 4 * s), expected_sample(frame, s),
             '1, RESP_OKAY);
endtask

// First eight, the last one, then 32 random picks
task automatic read_frame_samples(input int frame);
  int s;
  for (int i = 0; i < 8; i++) begin
    read_sample(i, frame);
  end
  read_sample(FRAME_WORDS * LANES - 1, frame);
  for (int i = 0; i < 32; i++) begin
    s = $unsigned($random(seed)) % (FRAME_WORDS * LANES);
    read_sample(s, frame);
  end
endtask

// Poll status until a valid bank holds a frame newer than after_frame
task automatic wait_new_frame(input int after_frame, output logic [SAMPLE_WIDTH-1:0] status);
  int start;
  logic [1:0] resp;
  logic seen;
  start  = cycle_cnt;
  seen   = 1'b0;
  status = '0;
  while (!seen && (cycle_cnt - start) < FRAME_WAIT_LIMIT) begin
    axi_read(ADDR_STATUS, status, resp);
    seen = status[16] && (int'(status[15:0]) > after_frame);
  end
  if (!seen) begin
    $display("Timeout at %0t: no new frame became readable", $time);
    err_cnt++;
  end
endtask

//--- test/tb_capture_top.sv
`timescale 1ns/1ps

module tb_capture_top;
  import cap_pkg::*;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic [AXI_ADDR_WIDTH-1:0] awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [SAMPLE_WIDTH-1:0]   wdata;
  logic                      wvalid;
  logic                      wready;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;
  logic [AXI_ADDR_WIDTH-1:0] araddr;
  logic                      arvalid;
  logic                      arready;
  logic [SAMPLE_WIDTH-1:0]   rdata;
  logic [1:0]                rresp;
  logic                      rvalid;
  logic                      rready;

  int err_cnt   = 0;
  int chk_cnt   = 0;
  int test_cnt  = 0;
  int test_base = 0;
  int cycle_cnt = 0;
  int seed;

  `include "capture_tb_tasks.svh"

  read_rec_t rec;

  capture_top u_dut (.*);

  // 100 ns clock
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(negedge clk) begin
    while (read_q.size() > 0) begin
      rec = read_q.pop_front();
      chk_cnt++;
      assert ((rec.got & rec.mask) == (rec.exp & rec.mask)) else begin
        $display("Mismatch at %0t: rdata (addr %h) got %h expected %h", $time, rec.addr,
                 rec.got & rec.mask, rec.exp & rec.mask);
        err_cnt++;
      end
      assert (rec.resp_got == rec.resp_exp) else begin
        $display("Mismatch at %0t: rresp (addr %h) got %0d expected %0d", $time, rec.addr,
                 rec.resp_got, rec.resp_exp);
        err_cnt++;
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Let queued reads reach the compare process, then report the test
  task automatic finish_test(input string name);
    int n;
    n = 0;
    while (read_q.size() > 0 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (read_q.size() > 0) begin
      $display("Compare queue still holds %0d reads", read_q.size());
      err_cnt++;
    end
    test_cnt++;
    $display("Test %0d %s: %s", test_cnt, name, (err_cnt == test_base) ? "passed" : "FAILED");
    test_base = err_cnt;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [SAMPLE_WIDTH-1:0] status;
    logic [1:0]              resp;
    int                      f;
    int                      g;
    logic                    bank_f;
    seed    = 49905;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Nothing readable yet, freeze clear
    check_read(ADDR_STATUS, 32'h0, 32'h0001_0000, RESP_OKAY);
    check_read(ADDR_CONTROL, 32'h0, '1, RESP_OKAY);
    finish_test("reset state");

    // First frame, then freeze and read it
    wait_new_frame(-1, status);
    axi_write(ADDR_CONTROL, 32'h1, resp);
    compare_value("bresp", 32'(resp), 32'(RESP_OKAY));
    axi_read(ADDR_STATUS, status, resp);
    f      = int'(status[15:0]);
    bank_f = status[17];
    read_frame_samples(f);
    finish_test("frozen frame read");

    // Bank must stay put over two more periods
    repeat (2 * FRAME_PERIOD + 20) @(negedge clk);
    check_read(ADDR_STATUS, {14'b0, bank_f, 1'b1, f[15:0]}, '1, RESP_OKAY);
    read_frame_samples(f);
    finish_test("freeze holds");

    // Release, catch a newer frame, freeze again
    axi_write(ADDR_CONTROL, 32'h0, resp);
    compare_value("bresp", 32'(resp), 32'(RESP_OKAY));
    wait_new_frame(f, status);
    axi_write(ADDR_CONTROL, 32'h1, resp);
    compare_value("bresp", 32'(resp), 32'(RESP_OKAY));
    axi_read(ADDR_STATUS, status, resp);
    g = int'(status[15:0]);
    assert (g > f) else begin
      $display("Frame number did not advance after release: %0d then %0d", f, g);
      err_cnt++;
    end
    // First handover after release comes from the spare bank
    compare_value("read_bank", {31'b0, status[17]}, {31'b0, !bank_f});
    read_frame_samples(g);
    finish_test("release and refreeze");

    // Unmapped read, writes to read-only space
    check_read(16'h2000, 32'h0, '1, RESP_SLVERR);
    axi_write(ADDR_STATUS, 32'h0, resp);
    compare_value("bresp", 32'(resp), 32'(RESP_SLVERR));
    axi_write(AXI_ADDR_WIDTH'(ADDR_SAMPLE_BASE + 16'h10), 32'h4, resp);
    compare_value("bresp", 32'(resp), 32'(RESP_SLVERR));
    check_read(ADDR_CONTROL, 32'h1, '1, RESP_OKAY);
    finish_test("error responses");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
